/* hdl/aim_settings.svh */
`ifndef AIM_SETTINGS_SVH
`define AIM_SETTINGS_SVH

// Horizontal raster in pixel clocks
`define H_ACTIVE     16
`define H_BLANK      16
// Sync position counted from the start of the blank
`define H_SYNC_START 4
`define H_SYNC_LEN   4
`define H_TOTAL      (`H_ACTIVE + `H_BLANK)

// Vertical raster in lines
`define V_ACTIVE     4
`define V_BLANK      2
`define V_TOTAL      (`V_ACTIVE + `V_BLANK)

// Per-camera pixel buffer
`define FIFO_DEPTH   32
`define FIFO_AW      5

// Camera 1 fill level that lets the raster start
`define START_THRESH 8

`endif

/* hdl/aim_pkg.sv */
`include "aim_settings.svh"

package aim_pkg;

    // Each camera fills half of a display line
    localparam int HALF_W = `H_ACTIVE / 2;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // One camera input beat
    typedef struct packed {
        logic       href;
        logic       valid;
        logic [7:0] data;
    } cam_byte_t;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       de;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } vid_out_t;

    typedef enum logic {
        WAIT_FILL,
        RUN
    } sync_state_e;

endpackage : aim_pkg

/* hdl/cam_byte_pack.sv */
`timescale 1ns/1ps

module cam_byte_pack
    import aim_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  cam_byte_t cam,
    output rgb565_t   pix,
    output logic      pix_valid
);

    logic       phase;
    logic [7:0] first_byte;
    logic       beat;

    // A byte counts only inside href
    assign beat = cam.valid && cam.href;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= beat && phase;
            if (!cam.href) begin
                // Drop a half-finished pair
                phase <= 1'b0;
            end else if (cam.valid) begin
                phase <= ~phase;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat && !phase) begin
            first_byte <= cam.data;
        end
        if (beat && phase) begin
            // First byte is r and g[5:3], second is g[2:0] and b
            pix.r <= first_byte[7:3];
            pix.g <= {first_byte[2:0], cam.data[7:5]};
            pix.b <= cam.data[4:0];
        end
    end

endmodule : cam_byte_pack

/* hdl/pixel_fifo.sv */
`timescale 1ns/1ps

`include "aim_settings.svh"

module pixel_fifo
    import aim_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  rgb565_t            wr_data,
    input  logic               rd_en,
    output rgb565_t            rd_data,
    output logic [`FIFO_AW:0]  level,
    output logic               overflow,
    output logic               underflow
);

    localparam logic [`FIFO_AW:0] FULL_LEVEL = `FIFO_DEPTH;

    rgb565_t             mem [`FIFO_DEPTH];
    logic [`FIFO_AW-1:0] wr_ptr;
    logic [`FIFO_AW-1:0] rd_ptr;
    logic                full;
    logic                empty;
    logic                do_wr;
    logic                do_rd;

    assign full  = (level == FULL_LEVEL);
    assign empty = (level == '0);
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Flags mark the cycle of the refused access
    assign overflow  = wr_en && full;
    assign underflow = rd_en && empty;

    // Show-ahead read
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule : pixel_fifo

/* hdl/pixel_combine.sv */
`timescale 1ns/1ps

`include "aim_settings.svh"

module pixel_combine
    import aim_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  rgb565_t           pix_1,
    input  logic              pix_valid_1,
    input  rgb565_t           pix_2,
    input  logic              pix_valid_2,
    input  logic              read_en,
    output logic [`FIFO_AW:0] level_1,
    output logic [7:0]        r,
    output logic [7:0]        g,
    output logic [7:0]        b,
    output logic              error
);

    localparam int CNT_W = $clog2(`H_ACTIVE) + 1;
    localparam logic [CNT_W-1:0] SPLIT = CNT_W'(HALF_W);

    logic [CNT_W-1:0] rd_cnt;
    logic             sel_2;
    logic             rd_en_1;
    logic             rd_en_2;
    rgb565_t          rd_data_1;
    rgb565_t          rd_data_2;
    logic             overflow_1;
    logic             overflow_2;
    logic             underflow_1;
    logic             underflow_2;
    rgb565_t          pix_sel;
    logic             pix_empty;
    rgb565_t          pix_q;

    // Left half of the line from camera 1, right half from camera 2
    assign sel_2   = (rd_cnt >= SPLIT);
    assign rd_en_1 = read_en && !sel_2;
    assign rd_en_2 = read_en && sel_2;

    pixel_fifo u_fifo_1 (
        .clk      (clk        ),
        .rst_n    (rst_n      ),
        .wr_en    (pix_valid_1),
        .wr_data  (pix_1      ),
        .rd_en    (rd_en_1    ),
        .rd_data  (rd_data_1  ),
        .level    (level_1    ),
        .overflow (overflow_1 ),
        .underflow(underflow_1)
    );

    pixel_fifo u_fifo_2 (
        .clk      (clk        ),
        .rst_n    (rst_n      ),
        .wr_en    (pix_valid_2),
        .wr_data  (pix_2      ),
        .rd_en    (rd_en_2    ),
        .rd_data  (rd_data_2  ),
        .level    (           ),
        .overflow (overflow_2 ),
        .underflow(underflow_2)
    );

    assign pix_sel   = sel_2 ? rd_data_2 : rd_data_1;
    assign pix_empty = sel_2 ? underflow_2 : underflow_1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_cnt <= '0;
            error  <= 1'b0;
        end else begin
            // Position restarts once the line's strobes end
            rd_cnt <= read_en ? rd_cnt + 1'b1 : '0;
            error  <= error | overflow_1 | overflow_2 | underflow_1 | underflow_2;
        end
    end

    // Black in blanking and when the FIFO ran dry
    always_ff @(posedge clk) begin
        if (read_en && !pix_empty) begin
            pix_q <= pix_sel;
        end else begin
            pix_q <= '0;
        end
    end

    assign r = {pix_q.r, 3'b000};
    assign g = {pix_q.g, 2'b00};
    assign b = {pix_q.b, 3'b000};

endmodule : pixel_combine

/* hdl/sync_gen.sv */
`timescale 1ns/1ps

`include "aim_settings.svh"

module sync_gen
    import aim_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [`FIFO_AW:0] level_1,
    output logic              read_en,
    output logic              hsync,
    output logic              vsync,
    output logic              de
);

    localparam int HW = $clog2(`H_TOTAL);
    localparam int VW = $clog2(`V_TOTAL);

    localparam logic [HW-1:0] H_LAST = HW'(`H_TOTAL - 1);
    localparam logic [VW-1:0] V_LAST = VW'(`V_TOTAL - 1);

    // Sync windows sit in the blank after the active region
    localparam int HS_BEGIN = `H_ACTIVE + `H_SYNC_START;
    localparam int HS_END   = HS_BEGIN + `H_SYNC_LEN;
    localparam int VS_LINE  = `V_ACTIVE;

    localparam logic [`FIFO_AW:0] THRESH = `START_THRESH;

    sync_state_e   state;
    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;
    logic          run;

    assign run = (state == RUN);

    // One cycle ahead of de to cover the FIFO read register
    assign read_en = run && (h_cnt < `H_ACTIVE) && (v_cnt < `V_ACTIVE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= WAIT_FILL;
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            case (state)
                WAIT_FILL: begin
                    // Counters are at zero here, so RUN opens a new frame
                    if (level_1 >= THRESH) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (h_cnt == H_LAST) begin
                        h_cnt <= '0;
                        v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                default: state <= WAIT_FILL;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de    <= 1'b0;
            hsync <= 1'b0;
            vsync <= 1'b0;
        end else begin
            de    <= read_en;
            hsync <= run && (h_cnt >= HS_BEGIN) && (h_cnt < HS_END);
            vsync <= run && (v_cnt == VS_LINE);
        end
    end

endmodule : sync_gen

/* hdl/aim_top.sv */
`timescale 1ns/1ps

`include "aim_settings.svh"

module aim_top
    import aim_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  cam_byte_t cam1,
    input  cam_byte_t cam2,
    output vid_out_t  vid,
    output logic      error
);

    rgb565_t           pix_1;
    rgb565_t           pix_2;
    logic              pix_valid_1;
    logic              pix_valid_2;
    logic              read_en;
    logic [`FIFO_AW:0] level_1;
    logic [7:0]        r;
    logic [7:0]        g;
    logic [7:0]        b;
    logic              hsync;
    logic              vsync;
    logic              de;

    cam_byte_pack u_cam1_pack (
        .clk      (clk        ),
        .rst_n    (rst_n      ),
        .cam      (cam1       ),
        .pix      (pix_1      ),
        .pix_valid(pix_valid_1)
    );

    cam_byte_pack u_cam2_pack (
        .clk      (clk        ),
        .rst_n    (rst_n      ),
        .cam      (cam2       ),
        .pix      (pix_2      ),
        .pix_valid(pix_valid_2)
    );

    pixel_combine u_pixel_combine (
        .clk        (clk        ),
        .rst_n      (rst_n      ),
        .pix_1      (pix_1      ),
        .pix_valid_1(pix_valid_1),
        .pix_2      (pix_2      ),
        .pix_valid_2(pix_valid_2),
        .read_en    (read_en    ),
        .level_1    (level_1    ),
        .r          (r          ),
        .g          (g          ),
        .b          (b          ),
        .error      (error      )
    );

    sync_gen u_sync_gen (
        .clk    (clk    ),
        .rst_n  (rst_n  ),
        .level_1(level_1),
        .read_en(read_en),
        .hsync  (hsync  ),
        .vsync  (vsync  ),
        .de     (de     )
    );

    assign vid = '{hsync: hsync, vsync: vsync, de: de, r: r, g: g, b: b};

endmodule : aim_top

/* tb/aim_top_tb.sv */
`timescale 1ns/1ps

`include "aim_settings.svh"

module aim_top_tb
    import aim_pkg::*;
();

    localparam int CLK_PERIOD    = 4;
    localparam int NORMAL_FRAMES = 3;
    localparam int TOTAL_FRAMES  = 5;
    localparam int MARGIN_CYCLES = 600;
    localparam int RUN_CYCLES    = TOTAL_FRAMES * `H_TOTAL * `V_TOTAL + MARGIN_CYCLES;

    logic      clk = 1'b0;
    logic      rst_n;
    cam_byte_t cam1;
    cam_byte_t cam2;
    vid_out_t  vid;
    logic      error;

    // Pixels sent but not yet shown, as raw RGB565
    logic [15:0] q1 [$];
    logic [15:0] q2 [$];

    logic [15:0] lfsr_state = 16'd54574;
    logic        line_on [1:2];
    logic        byte_hi [1:2];
    logic [15:0] cur_pix [1:2];
    int          px_left [1:2];
    int          sent    [1:2];
    logic        stop_cam2;

    int   cycle;
    logic de_q;
    logic vsync_q;
    logic hsync_q;
    logic started;
    int   de_pos;
    int   last_rise;
    int   hs_rise;
    int   hs_count;
    int   vs_rise;
    int   lines_in_frame;
    int   frames_done;
    logic black_seen;
    int   black_cycle;

    aim_top aim_top_i (
        .clk  (clk  ),
        .rst_n(rst_n),
        .cam1 (cam1 ),
        .cam2 (cam2 ),
        .vid  (vid  ),
        .error(error)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s: got %0h, expected %0h", $time, what, got, exp);
            $display("Something failed");
            $fatal(1, "check failed: %s", what);
        end
    endtask

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
    endtask

    // Zero-filled low bits, fields taken from the RGB565 layout
    function automatic logic [23:0] to_rgb888(input logic [15:0] p);
        return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
    endfunction

    task automatic drive_camera(input int c, output cam_byte_t beat);
        logic [15:0] gap;
        logic [15:0] pix;
        int          fill;
        logic        enabled;
        beat    = '0;
        fill    = (c == 1) ? q1.size() : q2.size();
        // Camera 2 gets a head start of one line so it is ready for the right half
        enabled = (c == 1) ? (sent[2] >= HALF_W) : !stop_cam2;
        if (!line_on[c]) begin
            if (enabled && (fill + HALF_W <= `FIFO_DEPTH - HALF_W)) begin
                line_on[c] = 1'b1;
                byte_hi[c] = 1'b1;
                px_left[c] = HALF_W;
            end
        end else begin
            beat.href = 1'b1;
            take_bits(2, gap);
            if (gap[1:0] != 2'b00) begin
                beat.valid = 1'b1;
                if (byte_hi[c]) begin
                    take_bits(16, pix);
                    cur_pix[c] = pix;
                    beat.data  = pix[15:8];
                    byte_hi[c] = 1'b0;
                end else begin
                    beat.data  = cur_pix[c][7:0];
                    byte_hi[c] = 1'b1;
                    if (c == 1) begin
                        q1.push_back(cur_pix[c]);
                    end else begin
                        q2.push_back(cur_pix[c]);
                    end
                    sent[c]++;
                    px_left[c]--;
                    if (px_left[c] == 0) begin
                        line_on[c] = 1'b0;
                    end
                end
            end
        end
    endtask

    task automatic check_pixel();
        logic [15:0] pix;
        logic [23:0] exp;
        exp = '0;
        if (de_pos < HALF_W) begin
            check_value("camera 1 pixel available", q1.size() != 0, 1);
            pix = q1.pop_front();
            exp = to_rgb888(pix);
        end else if (q2.size() != 0) begin
            pix = q2.pop_front();
            exp = to_rgb888(pix);
        end else begin
            check_value("camera 2 empty only after it stopped", stop_cam2, 1);
            if (!black_seen) begin
                black_seen  = 1'b1;
                black_cycle = cycle;
            end
        end
        check_value("pixel rgb", {vid.r, vid.g, vid.b}, exp);
    endtask

    always @(posedge clk) begin
        cam_byte_t beat_1;
        cam_byte_t beat_2;
        if (!rst_n) begin
            cam1 <= '0;
            cam2 <= '0;
        end else begin
            drive_camera(2, beat_2);
            drive_camera(1, beat_1);
            cam1 <= beat_1;
            cam2 <= beat_2;
        end
    end

    // Outputs are registered on the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        cycle++;
        if (!rst_n) begin
            check_value("de in reset", vid.de, 0);
            check_value("hsync in reset", vid.hsync, 0);
            check_value("vsync in reset", vid.vsync, 0);
            check_value("error in reset", error, 0);
        end else begin
            check_value("hsync with de", vid.hsync & vid.de, 0);
            if (vid.de && !de_q) begin
                if (!started) begin
                    check_value("start threshold", sent[1] >= `START_THRESH, 1);
                    started = 1'b1;
                end
                if (lines_in_frame > 0) begin
                    check_value("line period", cycle - last_rise, `H_TOTAL);
                end
                last_rise = cycle;
                de_pos    = 0;
            end
            if (vid.de) begin
                check_pixel();
                de_pos++;
            end
            if (!vid.de && de_q) begin
                check_value("de cycles per line", de_pos, `H_ACTIVE);
                lines_in_frame++;
            end
            // Every line, blank ones too, has its hsync at a fixed place in the blank
            if (vid.hsync && !hsync_q) begin
                check_value("hsync after raster start", started, 1);
                check_value("hsync position", (cycle - last_rise) % `H_TOTAL,
                            `H_ACTIVE + `H_SYNC_START);
                hs_rise = cycle;
                hs_count++;
            end
            if (!vid.hsync && hsync_q) begin
                check_value("hsync width", cycle - hs_rise, `H_SYNC_LEN);
            end
            if (vid.vsync && !vsync_q) begin
                check_value("lines per frame", lines_in_frame, `V_ACTIVE);
                check_value("hsync pulses per frame", hs_count,
                            (frames_done == 0) ? `V_ACTIVE : `V_TOTAL);
                lines_in_frame = 0;
                hs_count       = 0;
                vs_rise        = cycle;
                frames_done++;
            end
            if (!vid.vsync && vsync_q) begin
                check_value("vsync width", cycle - vs_rise, `H_TOTAL);
            end
            if (!black_seen) begin
                check_value("error before underflow", error, 0);
            end else if (cycle - black_cycle >= `H_TOTAL) begin
                check_value("error after underflow", error, 1);
            end
        end
        de_q    = vid.de;
        vsync_q = vid.vsync;
        hsync_q = vid.hsync;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", RUN_CYCLES);
        $display("Something failed");
        $fatal(1, "simulation timed out");
    end

    initial begin
        rst_n          = 1'b0;
        cam1           = '0;
        cam2           = '0;
        stop_cam2      = 1'b0;
        line_on        = '{1'b0, 1'b0};
        byte_hi        = '{1'b1, 1'b1};
        cur_pix        = '{16'h0, 16'h0};
        px_left        = '{0, 0};
        sent           = '{0, 0};
        cycle          = 0;
        de_q           = 1'b0;
        vsync_q        = 1'b0;
        hsync_q        = 1'b0;
        started        = 1'b0;
        de_pos         = 0;
        last_rise      = 0;
        hs_rise        = 0;
        hs_count       = 0;
        vs_rise        = 0;
        lines_in_frame = 0;
        frames_done    = 0;
        black_seen     = 1'b0;
        black_cycle    = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        wait (frames_done == NORMAL_FRAMES);
        // Starve camera 2 to exercise the underflow path
        stop_cam2 = 1'b1;
        wait (frames_done == TOTAL_FRAMES);
        check_value("black pixels from empty camera 2", black_seen, 1);
        check_value("sticky error at end", error, 1);
        $display("Everything OK");
        $finish;
    end

endmodule : aim_top_tb

/* aim_top.f */
+incdir+hdl
hdl/aim_pkg.sv
hdl/cam_byte_pack.sv
hdl/pixel_fifo.sv
hdl/pixel_combine.sv
hdl/sync_gen.sv
hdl/aim_top.sv
tb/aim_top_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f aim_top.f \
    --top-module aim_top_tb \
    -o aim_top_sim

# A $fatal in the testbench gives a failing exit status
./obj_dir/aim_top_sim
